/* hdl/flash_settings.svh */
// Build-time settings for the SPI flash reader, included by the package and the RTL that needs them
`ifndef FLASH_SETTINGS_SVH
`define FLASH_SETTINGS_SVH

// clock cycles to wait after reset before the flash is usable
`define FLASH_STARTUP_WAIT 32'd1000

// width of the requester's byte address, zero-extended to 24 bits on the wire
`define FLASH_ADDR_WIDTH 24

// standard SPI flash read opcode
`define FLASH_READ_CMD 8'h03

`endif

/* hdl/flashPkg.sv */
// Shared types for the SPI flash reader, imported by every RTL block of the reader
`default_nettype none

`include "flash_settings.svh"

package flashPkg;

  typedef logic [`FLASH_ADDR_WIDTH-1:0] flashAddr;
  typedef logic [7:0] flashByte;

  // opcode in the top byte, 24-bit address below, sent msb first
  typedef logic [31:0] flashHeader;

  // bits left in the current transfer phase
  typedef logic [5:0] flashBitCount;

  typedef enum logic [2:0] {
    sWaitPower,
    sIdle,
    sHeader,
    sRead,
    sDone
  } flashState;

endpackage

`default_nettype wire

/* hdl/spiClockTimer.sv */
// Power-up delay and SPI mode 0 clock generator; runs one phase of numBits bits per startBits pulse
`default_nettype none

`include "flash_settings.svh"

module spiClockTimer (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    startBits,
  input  wire flashPkg::flashBitCount numBits,
  output logic                   startupDone,
  output logic                   flashClk,
  output logic                   sclkFall,
  output logic                   sclkRise,
  output logic                   bitsDone
);
  import flashPkg::*;

  logic [31:0]  waitCount;
  logic         running;
  logic         phaseHigh;
  flashBitCount bitsLeft;

  // flash needs time after power-up before the first command
  always_ff @(posedge clk) begin
    if (rst) begin
      waitCount   <= '0;
      startupDone <= 1'b0;
    end else if (!startupDone) begin
      waitCount <= waitCount + 32'd1;
      if (waitCount == `FLASH_STARTUP_WAIT - 32'd1) begin
        startupDone <= 1'b1;
      end
    end
  end

  // strobes lead the pin by one edge so the shifter updates in step with flashClk
  assign sclkFall = running & ~phaseHigh;
  assign sclkRise = running & phaseHigh;

  always_ff @(posedge clk) begin
    if (rst) begin
      running   <= 1'b0;
      phaseHigh <= 1'b0;
      bitsLeft  <= '0;
      flashClk  <= 1'b0;
      bitsDone  <= 1'b0;
    end else begin
      bitsDone <= 1'b0;
      // high only for the half after a rise strobe, low otherwise
      flashClk <= sclkRise;

      if (startBits) begin
        running   <= 1'b1;
        phaseHigh <= 1'b0;
        bitsLeft  <= numBits;
      end else if (sclkFall) begin
        phaseHigh <= 1'b1;
      end else if (sclkRise) begin
        phaseHigh <= 1'b0;
        bitsLeft  <= bitsLeft - flashBitCount'(1);
        if (bitsLeft == flashBitCount'(1)) begin
          running  <= 1'b0;
          bitsDone <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/spiShifter.sv */
// Shift datapath of the flash reader: read header out on MOSI, byte in from MISO, and the held output byte
`default_nettype none

`include "flash_settings.svh"

module spiShifter (
  input  wire                clk,
  input  wire                rst,
  input  wire                loadHeader,
  input  wire flashPkg::flashAddr addr,
  input  wire                sclkFall,
  input  wire                sclkRise,
  input  wire                captureByte,
  input  wire                flashMiso,
  output logic               flashMosi,
  output flashPkg::flashByte data
);
  import flashPkg::*;

  localparam int headerMsb = $bits(flashHeader) - 1;

  flashHeader header;
  flashByte   rxByte;

  // command then address, zero-extended to the 24 address bits on the wire
  always_ff @(posedge clk) begin
    if (loadHeader) begin
      header <= {`FLASH_READ_CMD, 24'(addr)};
    end else if (sclkFall) begin
      header <= {header[headerMsb-1:0], 1'b0};
    end
  end

  // samples during the header too, only the last eight bits count
  always_ff @(posedge clk) begin
    if (sclkRise) begin
      rxByte <= {rxByte[$bits(flashByte)-2:0], flashMiso};
    end
  end

  // mosi changes as flashClk falls, stable across the rise
  always_ff @(posedge clk) begin
    if (rst) begin
      flashMosi <= 1'b0;
    end else if (sclkFall) begin
      flashMosi <= header[headerMsb];
    end
  end

  // held for the requester until the next read completes
  always_ff @(posedge clk) begin
    if (rst) begin
      data <= '0;
    end else if (captureByte) begin
      data <= rxByte;
    end
  end

endmodule

`default_nettype wire

/* hdl/flashSequencer.sv */
// Read sequencer of the flash reader: power-up wait, header and data phases, and the req/ack handshake
`default_nettype none

module flashSequencer (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    req,
  input  wire                    startupDone,
  input  wire                    bitsDone,
  output logic                   ack,
  output logic                   flashCs,
  output logic                   loadHeader,
  output logic                   startBits,
  output flashPkg::flashBitCount numBits,
  output logic                   captureByte
);
  import flashPkg::*;

  // phase lengths follow the widths of what is shifted
  localparam flashBitCount headerBits = flashBitCount'($bits(flashHeader));
  localparam flashBitCount readBits   = flashBitCount'($bits(flashByte));

  flashState state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= sWaitPower;
      ack     <= 1'b0;
      flashCs <= 1'b1;
    end else begin
      case (state)
        sWaitPower: begin
          if (startupDone) begin
            state <= sIdle;
          end
        end

        // ack is always low here, so a high req is a new request
        sIdle: begin
          if (req) begin
            flashCs <= 1'b0;
            state   <= sHeader;
          end
        end

        sHeader: begin
          if (bitsDone) begin
            state <= sRead;
          end
        end

        // data is captured on this same edge, so ack and data rise together
        sRead: begin
          if (bitsDone) begin
            flashCs <= 1'b1;
            ack     <= 1'b1;
            state   <= sDone;
          end
        end

        // hold the byte until the requester lets go
        sDone: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= sIdle;
          end
        end

        default: begin
          state <= sWaitPower;
        end
      endcase
    end
  end

  // strobes to timer and shifter, decoded from the current state
  always_comb begin
    loadHeader  = 1'b0;
    startBits   = 1'b0;
    numBits     = readBits;
    captureByte = 1'b0;

    case (state)
      sIdle: begin
        if (req) begin
          loadHeader = 1'b1;
          startBits  = 1'b1;
          numBits    = headerBits;
        end
      end

      sHeader: begin
        if (bitsDone) begin
          startBits = 1'b1;
          numBits   = readBits;
        end
      end

      sRead: begin
        if (bitsDone) begin
          captureByte = 1'b1;
        end
      end

      default: begin
        startBits = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/flashReader.sv */
// Top level of the SPI flash byte reader; instantiate it between the req/ack requester and the flash pins
`default_nettype none

module flashReader (
  input  wire                clk,
  input  wire                rst,
  input  wire                req,
  input  wire flashPkg::flashAddr addr,
  output logic               ack,
  output flashPkg::flashByte data,
  output logic               flashCs,
  output logic               flashClk,
  output logic               flashMosi,
  input  wire                flashMiso
);
  import flashPkg::*;

  logic         startupDone;
  logic         bitsDone;
  logic         loadHeader;
  logic         startBits;
  logic         captureByte;
  logic         sclkFall;
  logic         sclkRise;
  flashBitCount numBits;

  flashSequencer i_sequencer (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .startupDone (startupDone),
    .bitsDone    (bitsDone),
    .ack         (ack),
    .flashCs     (flashCs),
    .loadHeader  (loadHeader),
    .startBits   (startBits),
    .numBits     (numBits),
    .captureByte (captureByte)
  );

  spiClockTimer i_timer (
    .clk         (clk),
    .rst         (rst),
    .startBits   (startBits),
    .numBits     (numBits),
    .startupDone (startupDone),
    .flashClk    (flashClk),
    .sclkFall    (sclkFall),
    .sclkRise    (sclkRise),
    .bitsDone    (bitsDone)
  );

  spiShifter i_shifter (
    .clk         (clk),
    .rst         (rst),
    .loadHeader  (loadHeader),
    .addr        (addr),
    .sclkFall    (sclkFall),
    .sclkRise    (sclkRise),
    .captureByte (captureByte),
    .flashMiso   (flashMiso),
    .flashMosi   (flashMosi),
    .data        (data)
  );

endmodule

`default_nettype wire

/* testbench/spiFlashModel.sv */
// Behavioural SPI flash for the reader testbench; decodes one read per chip select, answers memByte
`default_nettype none

module spiFlashModel (
  input  wire         flashCs,
  input  wire         flashClk,
  input  wire         flashMosi,
  output logic        flashMiso,
  output logic [23:0] seenAddr,
  output logic        protocolError
);

  int          clocks;
  logic        selected;
  logic [31:0] shiftIn;
  logic [7:0]  outByte;

  // memory content, every address byte takes part
  function automatic logic [7:0] memByte(input logic [23:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5a;
  endfunction

  initial begin
    flashMiso = 1'b0;
    seenAddr = '0;
    protocolError = 1'b0;
    clocks = 0;
    selected = 1'b0;
    shiftIn = '0;
    outByte = '0;
  end

  always @(negedge flashCs) begin
    selected = 1'b1;
    clocks = 0;
  end

  always @(posedge flashCs) begin
    if (selected && clocks != 40) begin
      $display("flash model: %0d clocks in one chip-select window, not 40", clocks);
      protocolError = 1'b1;
    end
    selected = 1'b0;
  end

  // mode 0, mosi sampled on the rising clock
  always @(posedge flashClk) begin
    if (flashCs !== 1'b0) begin
      $display("flash model: flashClk toggled while flashCs was high");
      protocolError = 1'b1;
    end else begin
      shiftIn = {shiftIn[30:0], flashMosi};
      clocks = clocks + 1;
      if (clocks == 32) begin
        if (shiftIn[31:24] != 8'h03) begin
          $display("flash model: command %02h received instead of 03", shiftIn[31:24]);
          protocolError = 1'b1;
        end
        seenAddr = shiftIn[23:0];
        outByte = memByte(shiftIn[23:0]);
      end
    end
  end

  // data byte msb first, each bit presented on the falling clock
  always @(negedge flashClk) begin
    if (selected && clocks >= 32 && clocks < 40) begin
      flashMiso <= outByte[39 - clocks];
    end
  end

endmodule

`default_nettype wire

/* testbench/tbFlashReader.sv */
// Self-checking testbench for the SPI flash reader; compile with src.f and run tbFlashReader as top
`default_nettype none

`include "flash_settings.svh"

module tbFlashReader;
  import flashPkg::*;

  localparam int startupWait = `FLASH_STARTUP_WAIT;
  localparam int randomCount = 60;
  // one read raised during startup, five directed, the random ones
  localparam int totalReads = 1 + 5 + randomCount;
  localparam int watchdogCycles = 16 + startupWait + totalReads * 200;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        req = 1'b0;
  flashAddr    addr = '0;
  logic        ack;
  flashByte    data;
  logic        flashCs;
  logic        flashClk;
  logic        flashMosi;
  logic        flashMiso;
  logic [23:0] seenAddr;
  logic        protocolError;

  logic [31:0] lfsrState = 32'ha7f6a4b9;
  logic        ackPrev = 1'b0;
  int          readsChecked = 0;
  string       testName = "reset";

  always #4 clk = ~clk;

  flashReader i_dut (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .addr      (addr),
    .ack       (ack),
    .data      (data),
    .flashCs   (flashCs),
    .flashClk  (flashClk),
    .flashMosi (flashMosi),
    .flashMiso (flashMiso)
  );

  spiFlashModel i_flash (
    .flashCs       (flashCs),
    .flashClk      (flashClk),
    .flashMosi     (flashMosi),
    .flashMiso     (flashMiso),
    .seenAddr      (seenAddr),
    .protocolError (protocolError)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic takeBits(input int n, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
  endtask

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      failRun($sformatf("error: %s %s expected %0h actual %0h",
                        testName, what, expected, actual));
    end
  endtask

  // one full req/ack transaction, called at a rising edge
  task automatic readByte(input string name, input flashAddr a, input bit duringStartup);
    int          cycles;
    int          i;
    logic [31:0] hold;
    flashByte    heldData;
    testName = name;
    takeBits(4, hold);
    cycles = 0;
    req <= 1'b1;
    addr <= a;
    do begin
      @(posedge clk);
      cycles++;
      if (duringStartup && cycles <= startupWait) begin
        checkValue("flashCs in startup", 1, flashCs);
        checkValue("flashClk in startup", 0, flashClk);
        checkValue("ack in startup", 0, ack);
      end
    end while (ack !== 1'b1);
    heldData = data;
    // back-pressure, the reader must stay parked
    for (i = 0; i < int'(hold); i++) begin
      @(posedge clk);
      checkValue("ack held", 1, ack);
      checkValue("data held", 32'(heldData), 32'(data));
      checkValue("flashCs while held", 1, flashCs);
      checkValue("flashClk while held", 0, flashClk);
    end
    req <= 1'b0;
    @(posedge clk);
    checkValue("ack before req seen low", 1, ack);
    @(posedge clk);
    checkValue("ack after req low", 0, ack);
  endtask

  // compares every returned byte against the flash content
  always @(posedge clk) begin
    ackPrev <= ack;
    if (ack === 1'b1 && ackPrev === 1'b0) begin
      checkValue("data", 32'(i_flash.memByte(24'(addr))), 32'(data));
      checkValue("address at flash", 32'(24'(addr)), 32'(seenAddr));
      readsChecked <= readsChecked + 1;
    end
  end

  always @(posedge protocolError) begin
    failRun("the flash model saw a malformed SPI transaction");
  end

  initial begin
    repeat (watchdogCycles) @(posedge clk);
    failRun("timeout: the reader stopped answering requests");
  end

  initial begin : stimulus
    int          i;
    logic [31:0] randomAddr;
    // outputs are unknown until the first reset edge
    for (i = 0; i < 16; i++) begin
      @(posedge clk);
      if (i > 0) begin
        checkValue("flashCs in reset", 1, flashCs);
        checkValue("flashClk in reset", 0, flashClk);
        checkValue("ack in reset", 0, ack);
      end
    end
    rst <= 1'b0;
    readByte("startup read", 24'h000000, 1'b1);

    readByte("directed 000000", 24'h000000, 1'b0);
    readByte("directed 000001", 24'h000001, 1'b0);
    readByte("directed 0000ff", 24'h0000ff, 1'b0);
    readByte("directed 123456", 24'h123456, 1'b0);
    readByte("directed ffffff", 24'hffffff, 1'b0);

    for (i = 0; i < randomCount; i++) begin
      takeBits(`FLASH_ADDR_WIDTH, randomAddr);
      readByte("random read", flashAddr'(randomAddr), 1'b0);
    end

    repeat (2) @(posedge clk);
    testName = "summary";
    checkValue("reads compared", totalReads, readsChecked);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+hdl
hdl/flashPkg.sv
hdl/spiClockTimer.sv
hdl/spiShifter.sv
hdl/flashSequencer.sv
hdl/flashReader.sv
testbench/spiFlashModel.sv
testbench/tbFlashReader.sv
